// File: Makefile
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
src/fetch_pkg.sv
src/program_loader.sv
src/instr_rom.sv
src/pc_unit.sv
src/fetch_credit_out.sv
src/fetch_top.sv
sim/tb_fetch.sv

// File: sim/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    import fetch_pkg::*;

    localparam int rom_depth = 8;
    localparam int credits   = 4;
    localparam int words     = 2 ** rom_depth;

    typedef logic [rom_depth:0] uaddr_t;                 // upload address, msb is region

    logic               clk;
    logic               rst_n;
    logic               load_mode;
    logic               load_we;
    uaddr_t             load_addr;
    word_t              load_data;
    count_t             load_count;
    logic               branch_valid;
    word_t              branch_offset;
    logic               jump_valid;
    pc_t                jump_target;
    logic               credit_return;
    logic               out_valid;
    pc_t                out_pc;
    word_t              out_instr;

    integer seed;                                        // $random state
    int     errors;
    int     checks;

    // reference model
    word_t  shadow [words];                              // what the rom should hold
    pc_t    m_pc;                                        // pc register of the open cycle
    int     m_credits;
    int     idle;                                        // cycles with load_mode low, capped
    int     held;                                        // beats not yet returned
    logic   pred_issue;                                  // fetch expected in the open cycle
    logic   p_clear;
    logic   p_branch;
    logic   p_jump;
    logic   p_ret;
    word_t  p_offset;
    pc_t    p_target;

    fetch_top #(.ROM_DEPTH(rom_depth), .CREDITS(credits)) u_fetch_top (
        .clk(clk), .rst_n(rst_n),
        .load_mode(load_mode), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data), .load_count(load_count),
        .branch_valid(branch_valid), .branch_offset(branch_offset),
        .jump_valid(jump_valid), .jump_target(jump_target),
        .credit_return(credit_return), .out_valid(out_valid),
        .out_pc(out_pc), .out_instr(out_instr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                          // 40 ns period
    end

    // model runs mid-cycle, outputs and stimulus both settled
    always @(negedge clk) begin
        if (!rst_n) begin
            m_pc = '0;
            m_credits = credits;
            idle = 1;                                    // first cycle out of reset is dead
            held = 0;
            pred_issue = 1'b0;
            {p_clear, p_branch, p_jump, p_ret} = '0;
        end else begin
            checks = checks + 1;
            assert (out_valid === pred_issue) else begin
                $display("ERR out_valid exp %h got %h at pc %h", pred_issue, out_valid, m_pc);
                errors = errors + 1;
            end
            if (pred_issue && out_valid === 1'b1) begin
                checks = checks + 2;
                assert (out_pc === m_pc) else begin
                    $display("ERR out_pc exp %h got %h", m_pc, out_pc);
                    errors = errors + 1;
                end
                assert (out_instr === shadow[m_pc[rom_depth+1:2]]) else begin
                    $display("ERR out_instr exp %h got %h at pc %h",
                             shadow[m_pc[rom_depth+1:2]], out_instr, m_pc);
                    errors = errors + 1;
                end
            end
            if (out_valid === 1'b1) held = held + 1;
            assert (held <= credits) else begin
                $display("more beats outstanding than credits: %0d", held);
                errors = errors + 1;
            end
            // close the previous cycle, clear > branch > jump > sequential
            if (p_clear) m_pc = '0;
            else if (p_branch) m_pc = m_pc + 32'd4 + p_offset * 32'd4;
            else if (p_jump) m_pc = p_target;
            else if (pred_issue) m_pc = m_pc + 32'd4;
            if (pred_issue && !p_ret) m_credits = m_credits - 1;
            else if (p_ret && !pred_issue && m_credits < credits) m_credits = m_credits + 1;
            // open cycle
            idle = load_mode ? 0 : (idle < 3 ? idle + 1 : idle);
            p_clear  = (idle == 2);                      // clear lands one cycle after the fall
            p_branch = branch_valid;
            p_jump   = jump_valid;
            p_offset = branch_offset;
            p_target = jump_target;
            p_ret    = credit_return;
            pred_issue = (idle >= 3) && (m_credits > 0) && !branch_valid && !jump_valid;
            if (credit_return) held = held - 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic int roll();
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'd100);                        // 0..99
    endfunction

    task automatic quiet_inputs();
        load_we = 1'b0;
        credit_return = 1'b0;
        branch_valid = 1'b0;
        jump_valid = 1'b0;
    endtask

    // host upload, n writes, sequential or random addresses
    task automatic upload(input int n, input bit seq, input bit mix);
        int     lower;
        uaddr_t a;
        lower = 0;
        next_cycle();
        quiet_inputs();
        load_mode = 1'b1;                                // lets the last fetch drain first
        for (int i = 0; i < n; i++) begin
            next_cycle();
            a = seq ? uaddr_t'(i) : uaddr_t'($random(seed));
            if (!mix) a[rom_depth] = 1'b0;
            load_we = 1'b1;
            load_addr = a;
            load_data = $random(seed);
            if (!a[rom_depth]) begin
                shadow[a[rom_depth-1:0]] = load_data;
                lower = lower + 1;
            end
        end
        next_cycle();
        load_we = 1'b0;
        load_mode = 1'b0;
        checks = checks + 1;
        assert (load_count === count_t'(lower)) else begin
            $display("ERR load_count exp %h got %h", count_t'(lower), load_count);
            errors = errors + 1;
        end
    endtask

    // eager consumer until fetch restarts at zero
    task automatic wait_first_beat(input string what);
        int n;
        n = 0;
        do begin
            next_cycle();
            quiet_inputs();
            credit_return = (held + int'(out_valid) > 0);
            n = n + 1;
        end while (out_valid !== 1'b1 && n < 40);
        if (out_valid !== 1'b1) begin
            $display("timeout: no fetch beat within 40 cycles after %s", what);
            errors = errors + 1;
        end else begin
            checks = checks + 1;
            assert (out_pc === '0) else begin
                $display("ERR out_pc exp %h got %h after %s", 32'h0, out_pc, what);
                errors = errors + 1;
            end
        end
    endtask

    task automatic run_random(input int n, input int ret_pct, input int br_pct, input int jmp_pct);
        for (int i = 0; i < n; i++) begin
            next_cycle();
            credit_return = (held + int'(out_valid) > 0) && (roll() < ret_pct);
            branch_valid  = (roll() < br_pct);
            branch_offset = $random(seed) % 32;          // signed word count
            jump_valid    = (roll() < jmp_pct);
            jump_target   = $random(seed) & 32'hffff_fffc;
        end
        next_cycle();
        quiet_inputs();
    endtask

    task automatic report_test(input int num, input string name, input int base);
        if (errors == base) $display("test %0d %s: ok", num, name);
        else $display("test %0d %s: %0d errors", num, name, errors - base);
    endtask

    initial begin
        int base;
        seed = 33317;
        errors = 0;
        checks = 0;
        rst_n = 1'b0;
        load_mode = 1'b0;
        load_addr = '0;
        load_data = '0;
        branch_offset = '0;
        jump_target = '0;
        quiet_inputs();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        base = errors;
        upload(words, 1'b1, 1'b0);                       // fill every word
        wait_first_beat("first upload");
        run_random(200, 100, 0, 0);
        report_test(1, "sequential fetch", base);

        base = errors;
        run_random(300, 35, 0, 0);
        report_test(2, "random credit return", base);

        base = errors;
        run_random(300, 60, 15, 0);
        report_test(3, "branches", base);

        base = errors;
        run_random(300, 60, 10, 12);
        report_test(4, "jumps and branch priority", base);

        base = errors;
        upload(120, 1'b0, 1'b1);
        wait_first_beat("mixed region upload");
        run_random(300, 70, 5, 5);
        report_test(5, "upper region writes", base);

        base = errors;
        run_random(40, 50, 0, 0);
        upload(60, 1'b0, 1'b0);                          // reload while beats are held
        wait_first_beat("reload");
        run_random(250, 60, 5, 5);
        report_test(6, "reload mid run", base);

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/fetch_credit_out.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_credit_out #(
    parameter int CREDITS = fetch_pkg::default_credits
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    issue,                // fetch launched this cycle
    input  fetch_pkg::pc_t         issue_pc,
    input  fetch_pkg::word_t       rom_rdata,            // lands one cycle after issue

    input  wire                    credit_return,        // decode freed a slot

    output logic                   has_credit,
    output logic                   out_valid,            // one beat per fetch
    output fetch_pkg::pc_t         out_pc,
    output fetch_pkg::word_t       out_instr
);

    import fetch_pkg::*;

    localparam int cw = $clog2(CREDITS + 1);             // holds 0..CREDITS

    typedef logic [cw-1:0] credit_t;

    localparam credit_t credit_max = credit_t'(CREDITS);

    credit_t credit_cnt;                                 // slots free in decode
    credit_t credit_next;
    logic    valid_q;                                    // issue delayed one cycle
    pc_t     pc_q;                                       // pc of the beat in flight

    assign has_credit = (credit_cnt != '0);

    // credit taken at issue so back to back fetches see it at once
    always_comb begin
        credit_next = credit_cnt;
        case ({issue, credit_return})
            2'b10: credit_next = credit_cnt - 1'b1;
            2'b01: begin
                if (credit_cnt != credit_max) begin      // never above CREDITS
                    credit_next = credit_cnt + 1'b1;
                end
            end
            default: credit_next = credit_cnt;           // both or neither
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= credit_max;                    // full queue after reset
            valid_q    <= 1'b0;
        end else begin
            credit_cnt <= credit_next;
            valid_q    <= issue;
        end
    end

    // payload, lines up with rom data
    always_ff @(posedge clk) begin
        if (issue) begin
            pc_q <= issue_pc;
        end
    end

    assign out_valid = valid_q;
    assign out_pc    = pc_q;
    assign out_instr = rom_rdata;                        // rom holds it between reads

endmodule

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // instruction and pc width
    localparam int isa_width = 32;                       // load/store isa word

    // upload word counter width
    localparam int count_width = 16;                     // wide enough for any rom here

    // sizing defaults picked up by the top level
    localparam int default_rom_depth = 8;                // log2 of word count, 256 words
    localparam int default_credits = 4;                  // decode queue slots

    // instruction word, upload data and branch offset
    typedef logic [isa_width-1:0] word_t;

    // byte address for pc and jump target
    typedef logic [isa_width-1:0] pc_t;

    // accepted upload words
    typedef logic [count_width-1:0] count_t;

    // fetch control states
    typedef enum logic [1:0] {
        fs_load  = 2'd0,                                 // host upload in progress
        fs_run   = 2'd1,                                 // fetching
        fs_stall = 2'd2                                  // out of credits
    } fetch_state_t;

endpackage

`default_nettype wire

// File: src/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top #(
    parameter int ROM_DEPTH = fetch_pkg::default_rom_depth,
    parameter int CREDITS   = fetch_pkg::default_credits
) (
    input  wire                    clk,
    input  wire                    rst_n,

    // host upload
    input  wire                    load_mode,
    input  wire                    load_we,
    input  wire [ROM_DEPTH:0]      load_addr,            // upper half is data memory
    input  fetch_pkg::word_t       load_data,
    output fetch_pkg::count_t      load_count,

    // redirects from execute
    input  wire                    branch_valid,
    input  fetch_pkg::word_t       branch_offset,
    input  wire                    jump_valid,
    input  fetch_pkg::pc_t         jump_target,

    // decode side
    input  wire                    credit_return,
    output logic                   out_valid,
    output fetch_pkg::pc_t         out_pc,
    output fetch_pkg::word_t       out_instr
);

    import fetch_pkg::*;

    logic                 rom_we;                        // loader to rom
    logic [ROM_DEPTH-1:0] rom_waddr;
    word_t                rom_wdata;
    logic                 rom_re;                        // pc unit to rom
    logic [ROM_DEPTH-1:0] rom_raddr;
    word_t                rom_rdata;
    logic                 loading;                       // loader to pc unit
    logic                 pc_clear;
    logic                 has_credit;                    // credit side to pc unit
    logic                 issue;
    pc_t                  issue_pc;

    program_loader #(.ROM_DEPTH(ROM_DEPTH)) u_program_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_mode  (load_mode),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .rom_we     (rom_we),
        .rom_waddr  (rom_waddr),
        .rom_wdata  (rom_wdata),
        .loading    (loading),
        .pc_clear   (pc_clear),
        .load_count (load_count)
    );

    instr_rom #(.ROM_DEPTH(ROM_DEPTH)) u_instr_rom (
        .clk   (clk),
        .we    (rom_we),
        .waddr (rom_waddr),
        .wdata (rom_wdata),
        .re    (rom_re),
        .raddr (rom_raddr),
        .rdata (rom_rdata)
    );

    pc_unit #(.ROM_DEPTH(ROM_DEPTH)) u_pc_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .loading       (loading),
        .pc_clear      (pc_clear),
        .branch_valid  (branch_valid),
        .branch_offset (branch_offset),
        .jump_valid    (jump_valid),
        .jump_target   (jump_target),
        .has_credit    (has_credit),
        .issue         (issue),
        .issue_pc      (issue_pc),
        .rom_re        (rom_re),
        .rom_raddr     (rom_raddr)
    );

    fetch_credit_out #(.CREDITS(CREDITS)) u_fetch_credit_out (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue         (issue),
        .issue_pc      (issue_pc),
        .rom_rdata     (rom_rdata),
        .credit_return (credit_return),
        .has_credit    (has_credit),
        .out_valid     (out_valid),
        .out_pc        (out_pc),
        .out_instr     (out_instr)
    );

endmodule

`default_nettype wire

// File: src/instr_rom.sv
`timescale 1ns/1ps
`default_nettype none

module instr_rom #(
    parameter int ROM_DEPTH = fetch_pkg::default_rom_depth
) (
    input  wire                    clk,

    // upload write port
    input  wire                    we,
    input  wire [ROM_DEPTH-1:0]    waddr,                // word address
    input  fetch_pkg::word_t       wdata,

    // fetch read port
    input  wire                    re,                   // one read per issued fetch
    input  wire [ROM_DEPTH-1:0]    raddr,                // word address, pc / 4
    output fetch_pkg::word_t       rdata                 // valid one cycle after re
);

    import fetch_pkg::*;

    localparam int words = 2 ** ROM_DEPTH;               // instruction word count

    word_t mem [words];                                  // single block ram

    // write side, fed only during uploads
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read
    // output keeps its last word while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];                         // old data on same-edge write
        end
    end

endmodule

`default_nettype wire

// File: src/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
    parameter int ROM_DEPTH = fetch_pkg::default_rom_depth
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    loading,              // upload in progress
    input  wire                    pc_clear,             // restart at zero

    input  wire                    branch_valid,         // relative redirect
    input  fetch_pkg::word_t       branch_offset,        // signed word count
    input  wire                    jump_valid,           // absolute redirect
    input  fetch_pkg::pc_t         jump_target,          // byte address

    input  wire                    has_credit,           // from output side

    output logic                   issue,                // fetch this cycle
    output fetch_pkg::pc_t         issue_pc,
    output logic                   rom_re,
    output logic [ROM_DEPTH-1:0]   rom_raddr
);

    import fetch_pkg::*;

    pc_t          pc;                                    // current fetch address
    pc_t          pc_next;
    fetch_state_t state;
    fetch_state_t state_next;
    logic         redirect;                              // squashes this cycle's fetch

    assign redirect = branch_valid | jump_valid;

    // fetch issue
    // fs_load keeps issue low out of reset and across the clear
    assign issue = (state != fs_load) & ~loading & ~pc_clear & has_credit & ~redirect;

    assign issue_pc  = pc;
    assign rom_re    = issue;
    assign rom_raddr = pc[ROM_DEPTH+1:2];                // wraps in the rom

    // next pc, clear > branch > jump > sequential > hold
    always_comb begin
        if (pc_clear) begin
            pc_next = '0;
        end else if (branch_valid) begin
            pc_next = pc + 32'd4 + (branch_offset << 2); // offset in words
        end else if (jump_valid) begin
            pc_next = jump_target;
        end else if (issue) begin
            pc_next = pc + 32'd4;
        end else begin
            pc_next = pc;                                // stalled or loading
        end
    end

    // fetch FSM
    always_comb begin
        state_next = state;
        case (state)
            fs_load:  if (!loading) state_next = has_credit ? fs_run : fs_stall;
            fs_run:   if (loading) state_next = fs_load;
                      else if (!has_credit) state_next = fs_stall;
            fs_stall: if (loading) state_next = fs_load;
                      else if (has_credit) state_next = fs_run;
            default:  state_next = fs_load;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            state <= fs_load;                            // hold off first fetch
        end else begin
            pc    <= pc_next;
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: src/program_loader.sv
`timescale 1ns/1ps
`default_nettype none

module program_loader #(
    parameter int ROM_DEPTH = fetch_pkg::default_rom_depth
) (
    input  wire                    clk,
    input  wire                    rst_n,

    input  wire                    load_mode,            // host upload level
    input  wire                    load_we,              // one-cycle write strobe
    input  wire [ROM_DEPTH:0]      load_addr,            // msb selects region
    input  fetch_pkg::word_t       load_data,

    output logic                   rom_we,               // instruction region only
    output logic [ROM_DEPTH-1:0]   rom_waddr,
    output fetch_pkg::word_t       rom_wdata,

    output logic                   loading,              // blocks fetch
    output logic                   pc_clear,             // pulse after upload ends
    output fetch_pkg::count_t      load_count            // words written this upload
);

    import fetch_pkg::*;

    logic load_mode_q;                                   // last cycle's load_mode
    logic upload_start;                                  // rising edge of load_mode
    logic upload_end;                                    // falling edge of load_mode
    logic inst_wr;                                       // write into lower half

    assign upload_start = load_mode & ~load_mode_q;
    assign upload_end   = ~load_mode & load_mode_q;

    // upper half belongs to data memory, dropped here
    assign inst_wr = load_mode & load_we & ~load_addr[ROM_DEPTH];

    assign rom_we    = inst_wr;
    assign rom_waddr = inst_wr ? load_addr[ROM_DEPTH-1:0] : '0;  // quiet bus otherwise
    assign rom_wdata = inst_wr ? load_data : '0;

    // stretch by one cycle so nothing issues before the clear lands
    assign loading = load_mode | load_mode_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_mode_q <= 1'b0;
            pc_clear    <= 1'b0;
        end else begin
            load_mode_q <= load_mode;
            pc_clear    <= upload_end;                   // one cycle after the fall
        end
    end

    // word counter, restarts with each upload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_count <= '0;
        end else if (upload_start) begin
            load_count <= count_t'(inst_wr);             // first write may share the edge
        end else if (inst_wr) begin
            load_count <= load_count + 1'b1;
        end
    end

endmodule

`default_nettype wire
